// File: verilog/serv_isa_pkg.sv
package serv_isa_pkg;

   // Major opcodes of the kept instructions
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   // ADD, ADDI and BEQ share 000; BNE shares 001 with the dropped shifts
   typedef enum logic [2:0] {
      F3_ADD = 3'b000,
      F3_BNE = 3'b001,
      F3_SW  = 3'b010,
      F3_XOR = 3'b100,
      F3_OR  = 3'b110,
      F3_AND = 3'b111
   } funct3_e;

   // Field positions in the instruction word
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int F7_LSB  = 25;

   // Set in funct7 for SUB
   localparam int SUB_BIT = F7_LSB + 5;

endpackage

// File: verilog/serv_core_pkg.sv
package serv_core_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;
   localparam int REG_W = 5;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   typedef enum logic [1:0] {
      FETCH,
      DECODE,
      EXEC,
      STORE
   } core_state_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef struct packed {
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs1;
      logic [REG_W-1:0] rs2;
      alu_op_e          alu_op;
      logic             imm_sel;
      logic             rd_wen;
      logic             is_branch;
      logic             branch_ne;
      logic             is_store;
   } ctrl_t;

endpackage

// File: verilog/serv_state.sv
`timescale 1ns/1ns

module serv_state
   import serv_core_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_ibus_ack,
   input  logic             i_dbus_ack,
   input  logic             i_is_store,
   output logic             o_ibus_cyc,
   output logic             o_dbus_cyc,
   output logic [CNT_W-1:0] o_cnt,
   output logic             o_cnt_en,
   output logic             o_cnt_done,
   output logic             o_decode_en,
   output logic             o_pc_en
);

   core_state_e state;
   logic        ibus_cyc;
   logic        fetch_done;
   logic        store_done;

   assign fetch_done = ibus_cyc & i_ibus_ack;
   assign store_done = (state == STORE) & i_dbus_ack;

   assign o_ibus_cyc  = ibus_cyc;
   assign o_dbus_cyc  = (state == STORE);
   assign o_cnt_en    = (state == EXEC);
   assign o_cnt_done  = o_cnt_en & (o_cnt == CNT_W'(XLEN - 1));
   // Instruction word is only valid alongside the ack
   assign o_decode_en = fetch_done;
   assign o_pc_en     = (o_cnt_done & !i_is_store) | store_done;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= FETCH;
         ibus_cyc <= 1'b0;
         o_cnt    <= '0;
      end else begin
         // Wraps back to zero on the last serial cycle
         if (o_cnt_en)
            o_cnt <= o_cnt + 1'b1;

         case (state)
            FETCH: begin
               ibus_cyc <= !fetch_done;
               if (fetch_done)
                  state <= DECODE;
            end
            DECODE: begin
               state <= EXEC;
            end
            EXEC: begin
               if (o_cnt_done) begin
                  state    <= i_is_store ? STORE : FETCH;
                  ibus_cyc <= !i_is_store;
               end
            end
            STORE: begin
               if (i_dbus_ack) begin
                  state    <= FETCH;
                  ibus_cyc <= 1'b1;
               end
            end
            default: begin
               state <= FETCH;
            end
         endcase
      end
   end

endmodule

// File: verilog/serv_decode.sv
`timescale 1ns/1ns

module serv_decode
   import serv_core_pkg::*;
   import serv_isa_pkg::*;
(
   input  logic            clk,
   input  logic            i_decode_en,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_cnt_en,
   output ctrl_t           o_ctrl,
   output logic [XLEN-1:0] o_imm,
   output logic            o_imm_bit
);

   opcode_e         opcode;
   funct3_e         funct3;
   ctrl_t           ctrl_d;
   logic [XLEN-1:0] imm_d;
   logic [XLEN-1:0] imm_sr;

   assign opcode = opcode_e'(i_ibus_rdt[$bits(opcode_e)-1:0]);
   assign funct3 = funct3_e'(i_ibus_rdt[F3_LSB +: 3]);

   always_comb begin
      ctrl_d        = '0;
      ctrl_d.rd     = i_ibus_rdt[RD_LSB +: REG_W];
      ctrl_d.rs1    = i_ibus_rdt[RS1_LSB +: REG_W];
      ctrl_d.rs2    = i_ibus_rdt[RS2_LSB +: REG_W];
      ctrl_d.alu_op = ALU_ADD;
      imm_d         = '0;
      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            ctrl_d.imm_sel = (opcode == OPC_OP_IMM);
            ctrl_d.rd_wen  = 1'b1;
            imm_d          = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
            case (funct3)
               F3_ADD: begin
                  if (opcode == OPC_OP && i_ibus_rdt[SUB_BIT])
                     ctrl_d.alu_op = ALU_SUB;
               end
               F3_XOR:  ctrl_d.alu_op = ALU_XOR;
               F3_OR:   ctrl_d.alu_op = ALU_OR;
               F3_AND:  ctrl_d.alu_op = ALU_AND;
               // Shifts and compares retire as no-ops
               default: ctrl_d.rd_wen = 1'b0;
            endcase
         end
         OPC_LUI: begin
            ctrl_d.alu_op  = ALU_PASS_B;
            ctrl_d.imm_sel = 1'b1;
            ctrl_d.rd_wen  = 1'b1;
            imm_d          = {i_ibus_rdt[31:12], 12'b0};
         end
         OPC_BRANCH: begin
            ctrl_d.is_branch = (funct3 == F3_ADD) || (funct3 == F3_BNE);
            ctrl_d.branch_ne = (funct3 == F3_BNE);
            imm_d = {{19{i_ibus_rdt[31]}}, i_ibus_rdt[31], i_ibus_rdt[7],
                     i_ibus_rdt[30:25], i_ibus_rdt[11:8], 1'b0};
         end
         OPC_STORE: begin
            // Address is rs1 plus the S immediate
            ctrl_d.imm_sel  = 1'b1;
            ctrl_d.is_store = (funct3 == F3_SW);
            imm_d = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
         end
         default: begin
            ctrl_d.rd_wen = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_decode_en) begin
         o_ctrl <= ctrl_d;
         o_imm  <= imm_d;
         imm_sr <= imm_d;
      end else if (i_cnt_en) begin
         imm_sr <= {1'b0, imm_sr[XLEN-1:1]};
      end
   end

   assign o_imm_bit = imm_sr[0];

endmodule

// File: verilog/serv_rf.sv
`timescale 1ns/1ns

module serv_rf
   import serv_core_pkg::*;
(
   input  logic             clk,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_cnt_en,
   input  ctrl_t            i_ctrl,
   input  logic             i_rd_bit,
   output logic             o_rs1_bit,
   output logic             o_rs2_bit
);

   // x0 has no storage
   logic [XLEN-1:0] regs [1:(1 << REG_W) - 1];
   logic            wr_en;

   // Reads are combinational on the current bit index, so a bit is read
   // in the same cycle that precedes its write
   assign o_rs1_bit = (i_ctrl.rs1 == '0) ? 1'b0 : regs[i_ctrl.rs1][i_cnt];
   assign o_rs2_bit = (i_ctrl.rs2 == '0) ? 1'b0 : regs[i_ctrl.rs2][i_cnt];

   assign wr_en = i_cnt_en & i_ctrl.rd_wen & (i_ctrl.rd != '0);

   always_ff @(posedge clk) begin
      if (wr_en)
         regs[i_ctrl.rd][i_cnt] <= i_rd_bit;
   end

endmodule

// File: verilog/serv_alu.sv
`timescale 1ns/1ns

module serv_alu
   import serv_core_pkg::*;
(
   input  logic  clk,
   input  logic  i_cnt_en,
   input  logic  i_cnt_done,
   input  ctrl_t i_ctrl,
   input  logic  i_rs1_bit,
   input  logic  i_rs2_bit,
   input  logic  i_imm_bit,
   output logic  o_rd_bit,
   output logic  o_eq
);

   logic op_b;
   logic sub;
   logic b_add;
   logic carry_q;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic eq_q;
   logic running;

   assign op_b  = i_ctrl.imm_sel ? i_imm_bit : i_rs2_bit;
   assign sub   = (i_ctrl.alu_op == ALU_SUB);
   assign b_add = op_b ^ sub;

   // Carry is kept xor'ed with sub, so a cleared register means carry-in of 1 for SUB
   assign carry_in  = carry_q ^ sub;
   assign sum       = i_rs1_bit ^ b_add ^ carry_in;
   assign carry_out = (i_rs1_bit & b_add) | (carry_in & (i_rs1_bit ^ b_add));

   assign o_eq = eq_q & (i_rs1_bit == op_b);

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         ALU_PASS_B: o_rd_bit = op_b;
         default:    o_rd_bit = sum;
      endcase
   end

   // Outside the serial cycles both flags sit at their start values
   assign running = i_cnt_en & !i_cnt_done;

   always_ff @(posedge clk) begin
      carry_q <= running & (carry_out ^ sub);
      eq_q    <= running ? o_eq : 1'b1;
   end

endmodule

// File: verilog/serv_ctrl.sv
`timescale 1ns/1ns

module serv_ctrl
   import serv_core_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_pc_en,
   input  ctrl_t           i_ctrl,
   input  logic            i_eq,
   input  logic [XLEN-1:0] i_imm,
   output logic [XLEN-1:0] o_ibus_adr
);

   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] pc_next;
   logic            taken;

   // Equality is only final on the last serial cycle, which is when pc_en fires
   assign taken = i_ctrl.is_branch & (i_eq ^ i_ctrl.branch_ne);

   always_comb begin
      if (taken)
         pc_next = pc + i_imm;
      else
         pc_next = pc + XLEN'(4);
   end

   always_ff @(posedge clk) begin
      if (i_rst)
         pc <= RESET_PC;
      else if (i_pc_en)
         pc <= pc_next;
   end

   assign o_ibus_adr = pc;

endmodule

// File: verilog/serv_mem_if.sv
`timescale 1ns/1ns

module serv_mem_if
   import serv_core_pkg::*;
(
   input  logic            clk,
   input  logic            i_cnt_en,
   input  logic            i_addr_bit,
   input  logic            i_rs2_bit,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic [3:0]      o_dbus_sel
);

   // Bits enter at the top, so after 32 shifts bit 0 sits at the bottom
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         o_dbus_adr <= {i_addr_bit, o_dbus_adr[XLEN-1:1]};
         o_dbus_dat <= {i_rs2_bit, o_dbus_dat[XLEN-1:1]};
      end
   end

   // Whole-word stores only
   assign o_dbus_sel = 4'b1111;

endmodule

// File: verilog/serv_top.sv
`timescale 1ns/1ns

module serv_top
   import serv_core_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic [3:0]      o_dbus_sel,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc,
   input  logic            i_dbus_ack
);

   logic [CNT_W-1:0] cnt;
   logic             cnt_en;
   logic             cnt_done;
   logic             decode_en;
   logic             pc_en;
   ctrl_t            dec_ctrl;
   logic [XLEN-1:0]  imm;
   logic             imm_bit;
   logic             rs1_bit;
   logic             rs2_bit;
   logic             rd_bit;
   logic             eq;

   assign o_dbus_we = 1'b1;

   serv_state state (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_dbus_ack  (i_dbus_ack),
      .i_is_store  (dec_ctrl.is_store),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_dbus_cyc  (o_dbus_cyc),
      .o_cnt       (cnt),
      .o_cnt_en    (cnt_en),
      .o_cnt_done  (cnt_done),
      .o_decode_en (decode_en),
      .o_pc_en     (pc_en)
   );

   serv_decode decode (
      .clk         (clk),
      .i_decode_en (decode_en),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_cnt_en    (cnt_en),
      .o_ctrl      (dec_ctrl),
      .o_imm       (imm),
      .o_imm_bit   (imm_bit)
   );

   // Register file feeds the ALU directly
   serv_rf rf (
      .clk       (clk),
      .i_cnt     (cnt),
      .i_cnt_en  (cnt_en),
      .i_ctrl    (dec_ctrl),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serv_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_ctrl     (dec_ctrl),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .i_imm_bit  (imm_bit),
      .o_rd_bit   (rd_bit),
      .o_eq       (eq)
   );

   serv_ctrl ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_pc_en    (pc_en),
      .i_ctrl     (dec_ctrl),
      .i_eq       (eq),
      .i_imm      (imm),
      .o_ibus_adr (o_ibus_adr)
   );

   // For SW the ALU result is the address sum
   serv_mem_if mem_if (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_addr_bit (rd_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel)
   );

endmodule

// File: verification/serv_assert.sv
`timescale 1ns/1ns

module serv_assert
   import serv_core_pkg::*;
(
   input logic            clk,
   input logic            i_rst,
   input logic [XLEN-1:0] o_ibus_adr,
   input logic            o_ibus_cyc,
   input logic            i_ibus_ack,
   input logic [XLEN-1:0] o_dbus_adr,
   input logic [XLEN-1:0] o_dbus_dat,
   input logic            o_dbus_we,
   input logic            o_dbus_cyc,
   input logic            i_dbus_ack
);

   int fail_count = 0;

   ibus_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc)
   else begin
      $error("instruction bus request dropped before ack");
      fail_count++;
   end

   // Address and data must not move while the store waits
   dbus_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_dbus_cyc && !i_dbus_ack |=>
         o_dbus_cyc && $stable(o_dbus_adr) && $stable(o_dbus_dat))
   else begin
      $error("data bus request changed before ack");
      fail_count++;
   end

   // Only whole-word stores exist
   dbus_write_only: assert property (@(posedge clk) disable iff (i_rst)
      o_dbus_cyc |-> o_dbus_we)
   else begin
      $error("data bus request is not a write");
      fail_count++;
   end

   bus_exclusive: assert property (@(posedge clk) disable iff (i_rst)
      !(o_ibus_cyc && o_dbus_cyc))
   else begin
      $error("instruction and data bus active together");
      fail_count++;
   end

   ibus_aligned: assert property (@(posedge clk) disable iff (i_rst)
      o_ibus_cyc |-> o_ibus_adr[1:0] == 2'b00)
   else begin
      $error("instruction address not word aligned");
      fail_count++;
   end

   dbus_idle_after_reset: assert property (@(posedge clk)
      i_rst |=> !o_dbus_cyc)
   else begin
      $error("data bus active right after reset");
      fail_count++;
   end

endmodule

// File: verification/serv_tb.sv
`timescale 1ns/1ns

module serv_tb
   import serv_isa_pkg::*;
;

   localparam logic [31:0] START_PC = 32'h0;
   localparam int          MAX_WAIT = 20000;

   logic        clk = 1'b0;
   logic        i_rst;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic [3:0]  o_dbus_sel;
   logic        o_dbus_we;
   logic        o_dbus_cyc;
   logic        i_dbus_ack;

   logic [31:0] prog [0:255];
   int          prog_len;
   int          ibus_delay = -1;
   int          dbus_delay = -1;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_passed = 0;
   bit          timed_out = 1'b0;

   logic [31:0] fetch_log [$];
   logic [31:0] store_adr [$];
   logic [31:0] store_dat [$];
   logic [3:0]  store_sel [$];
   logic [31:0] exp_fetch [$];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];

   serv_top u_serv_top (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   bind serv_top serv_assert u_assert (.*);

   always #4 clk = ~clk;

   // Instruction memory with 0 to 3 cycles of wait
   always @(negedge clk) begin
      i_ibus_ack <= 1'b0;
      if (i_rst) begin
         ibus_delay = -1;
      end else if (o_ibus_cyc && !i_ibus_ack) begin
         if (ibus_delay < 0)
            ibus_delay = $urandom_range(3, 0);
         if (ibus_delay == 0) begin
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= prog[o_ibus_adr[9:2]];
            fetch_log.push_back(o_ibus_adr);
            ibus_delay = -1;
         end else begin
            ibus_delay--;
         end
      end
   end

   always @(negedge clk) begin
      i_dbus_ack <= 1'b0;
      if (i_rst) begin
         dbus_delay = -1;
      end else if (o_dbus_cyc && !i_dbus_ack) begin
         if (dbus_delay < 0)
            dbus_delay = $urandom_range(3, 0);
         if (dbus_delay == 0) begin
            i_dbus_ack <= 1'b1;
            store_adr.push_back(o_dbus_adr);
            store_dat.push_back(o_dbus_dat);
            store_sel.push_back(o_dbus_sel);
            dbus_delay = -1;
         end else begin
            dbus_delay--;
         end
      end
   end

   function automatic logic [31:0] r_type(bit sub, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
      return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
      return {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2,
                                          logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
      return {imm, rd, OPC_LUI};
   endfunction

   // Branch to itself ends a program
   function automatic logic [31:0] halt_word();
      return b_type(13'd0, 5'd0, 5'd0, F3_ADD);
   endfunction

   task automatic clear_prog();
      for (int i = 0; i < 256; i++)
         prog[i] = i_type(12'(i), 5'd0, F3_ADD, 5'd0);
      prog_len = 0;
   endtask

   task automatic emit(input logic [31:0] word);
      prog[prog_len] = word;
      prog_len++;
   endtask

   task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = value + 32'h800;
      emit(u_type(upper[31:12], rd));
      emit(i_type(value[11:0], rd, F3_ADD, rd));
   endtask

   // Instruction-level model of the kept subset
   task automatic run_model();
      logic [31:0] regs [32];
      logic [31:0] pc;
      logic [31:0] next_pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [2:0]  f3;
      bit          wr;
      exp_fetch.delete();
      exp_adr.delete();
      exp_dat.delete();
      foreach (regs[i])
         regs[i] = '0;
      pc = START_PC;
      for (int step = 0; step < 300; step++) begin
         exp_fetch.push_back(pc);
         ins = prog[pc[9:2]];
         if (ins == halt_word())
            break;
         f3 = ins[F3_LSB +: 3];
         a = regs[ins[RS1_LSB +: 5]];
         b = regs[ins[RS2_LSB +: 5]];
         res = '0;
         wr = 1'b0;
         next_pc = pc + 32'd4;
         case (ins[6:0])
            OPC_OP, OPC_OP_IMM: begin
               if (ins[6:0] == OPC_OP_IMM)
                  b = {{20{ins[31]}}, ins[31:20]};
               wr = 1'b1;
               case (f3)
                  3'b000:
                     res = (ins[6:0] == OPC_OP && ins[SUB_BIT]) ? a - b : a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: wr = 1'b0;
               endcase
            end
            OPC_LUI: begin
               res = {ins[31:12], 12'b0};
               wr = 1'b1;
            end
            OPC_BRANCH: begin
               if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                  next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                  ins[11:8], 1'b0};
            end
            OPC_STORE: begin
               if (f3 == 3'b010) begin
                  exp_adr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                  exp_dat.push_back(b);
               end
            end
            default: ;
         endcase
         if (wr && ins[RD_LSB +: 5] != 5'd0)
            regs[ins[RD_LSB +: 5]] = res;
         pc = next_pc;
      end
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic run_test(input string name);
      int cycles;
      int errors_before;
      if (timed_out)
         return;
      errors_before = errors;
      tests_run++;
      run_model();
      @(negedge clk);
      i_rst <= 1'b1;
      repeat (8) @(negedge clk);
      fetch_log.delete();
      store_adr.delete();
      store_dat.delete();
      store_sel.delete();
      i_rst <= 1'b0;
      cycles = 0;
      while (fetch_log.size() < exp_fetch.size() && cycles < MAX_WAIT) begin
         @(negedge clk);
         cycles++;
      end
      if (fetch_log.size() < exp_fetch.size()) begin
         $display("Test %s: timed out waiting for the core to reach the end of the program",
                  name);
         errors++;
         timed_out = 1'b1;
         return;
      end
      for (int i = 0; i < exp_fetch.size(); i++)
         check_value(name, $sformatf("fetch %0d address", i), exp_fetch[i], fetch_log[i]);
      check_value(name, "store count", exp_adr.size(), store_adr.size());
      for (int i = 0; i < exp_adr.size() && i < store_adr.size(); i++) begin
         check_value(name, $sformatf("store %0d address", i), exp_adr[i], store_adr[i]);
         check_value(name, $sformatf("store %0d data", i), exp_dat[i], store_dat[i]);
         check_value(name, $sformatf("store %0d sel", i), 32'hf, 32'(store_sel[i]));
      end
      if (errors == errors_before) begin
         tests_passed++;
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   initial begin
      i_rst = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      void'($urandom(82358));

      clear_prog();
      emit(i_type(12'd5, 5'd0, F3_ADD, 5'd1));
      emit(i_type(-12'sd3, 5'd1, F3_ADD, 5'd2));
      emit(i_type(12'd7, 5'd2, F3_XOR, 5'd3));
      emit(halt_word());
      run_test("fetch_sequence");

      clear_prog();
      load_const(5'd1, $urandom);
      emit(i_type(-12'sd1000, 5'd1, F3_ADD, 5'd2));
      emit(i_type(-12'sd16, 5'd1, F3_AND, 5'd3));
      emit(i_type(12'h7f0, 5'd1, F3_OR, 5'd4));
      emit(i_type(-12'sd1, 5'd1, F3_XOR, 5'd5));
      for (int r = 2; r <= 5; r++)
         emit(s_type(12'(4 * r), 5'(r), 5'd0));
      emit(halt_word());
      run_test("immediate_ops");

      clear_prog();
      load_const(5'd1, $urandom);
      load_const(5'd2, $urandom);
      emit(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd3));
      emit(r_type(1'b1, 5'd2, 5'd1, F3_ADD, 5'd4));
      emit(r_type(1'b0, 5'd2, 5'd1, F3_AND, 5'd5));
      emit(r_type(1'b0, 5'd2, 5'd1, F3_OR, 5'd6));
      emit(r_type(1'b0, 5'd2, 5'd1, F3_XOR, 5'd7));
      emit(r_type(1'b1, 5'd2, 5'd1, F3_ADD, 5'd1));
      // x0 is written and must still read back as zero
      emit(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd0));
      emit(r_type(1'b0, 5'd2, 5'd0, F3_ADD, 5'd8));
      for (int r = 0; r <= 8; r++)
         emit(s_type(12'(4 * r), 5'(r), 5'd0));
      emit(halt_word());
      run_test("register_ops");

      clear_prog();
      load_const(5'd9, $urandom);
      load_const(5'd10, 32'h8000_0fff);
      emit(s_type(12'h40, 5'd9, 5'd0));
      emit(s_type(12'h44, 5'd10, 5'd0));
      emit(halt_word());
      run_test("lui_addi_constant");

      clear_prog();
      emit(i_type(12'd5, 5'd0, F3_ADD, 5'd1));
      emit(i_type(12'd5, 5'd0, F3_ADD, 5'd2));
      emit(i_type(12'd7, 5'd0, F3_ADD, 5'd3));
      emit(b_type(13'd8, 5'd2, 5'd1, F3_ADD));
      emit(s_type(12'h100, 5'd1, 5'd0));
      emit(b_type(13'd8, 5'd3, 5'd1, F3_ADD));
      emit(s_type(12'h104, 5'd3, 5'd0));
      emit(b_type(13'd8, 5'd3, 5'd1, F3_BNE));
      emit(s_type(12'h108, 5'd1, 5'd0));
      emit(b_type(13'd8, 5'd2, 5'd1, F3_BNE));
      emit(s_type(12'h10c, 5'd2, 5'd0));
      // Backward loop runs three times
      emit(i_type(12'd3, 5'd0, F3_ADD, 5'd4));
      emit(i_type(-12'sd1, 5'd4, F3_ADD, 5'd4));
      emit(b_type(-13'sd4, 5'd0, 5'd4, F3_BNE));
      emit(s_type(12'h110, 5'd4, 5'd0));
      emit(halt_word());
      run_test("branches");

      clear_prog();
      load_const(5'd10, $urandom);
      load_const(5'd11, $urandom);
      emit(s_type(-12'sd4, 5'd11, 5'd10));
      emit(s_type(12'h7fc, 5'd11, 5'd10));
      emit(s_type(-12'sd2048, 5'd10, 5'd11));
      emit(halt_word());
      run_test("store_address");

      errors += u_serv_top.u_assert.fail_count;
      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_passed, tests_run - tests_passed, errors);
      if (errors == 0 && !timed_out) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
verilog/serv_isa_pkg.sv
verilog/serv_core_pkg.sv
verilog/serv_state.sv
verilog/serv_decode.sv
verilog/serv_rf.sv
verilog/serv_alu.sv
verilog/serv_ctrl.sv
verilog/serv_mem_if.sv
verilog/serv_top.sv
verification/serv_assert.sv
verification/serv_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= serv_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
